/* filelist.f */
verilog/core_pkg.sv
verilog/instruction_fetch.sv
verilog/register_status.sv
verilog/dispatch_unit.sv
verilog/alu_station.sv
verilog/result_bus_arbiter.sv
verilog/ooo_core.sv
tb/tb_clock.sv
tb/core_assertions.sv
tb/tb_top.sv

/* tb/core_assertions.sv */
module core_assertions import core_pkg::*; (
    input logic  clock,
    input logic  reset,
    input logic  mem_enable,
    input word_t mem_addr,
    input logic  mem_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0; // Read by the testbench top

    idle_in_reset: assert property (@(posedge clock) reset |-> !mem_enable)
        else begin
            $error("Memory request raised while reset is active");
            failures++;
        end

    first_request_at_zero: assert property (@(posedge clock)
        !reset && $past(reset) |=> mem_enable && mem_addr == '0)
        else begin
            $error("FAILED mem_addr 0x%08h, expected 0x00000000 on first request", mem_addr);
            failures++;
        end

    request_held: assert property (@(posedge clock) disable iff (reset)
        mem_enable && !mem_ready |=> mem_enable)
        else begin
            $error("Memory request dropped before mem_ready");
            failures++;
        end

    address_stable: assert property (@(posedge clock) disable iff (reset)
        mem_enable && !mem_ready |=> $stable(mem_addr))
        else begin
            $error("FAILED mem_addr 0x%08h, expected 0x%08h", mem_addr, $past(mem_addr));
            failures++;
        end

    idle_after_ready: assert property (@(posedge clock) disable iff (reset)
        mem_enable && mem_ready |=> !mem_enable)
        else begin
            $error("Memory request still active in the cycle after mem_ready");
            failures++;
        end

    word_aligned: assert property (@(posedge clock) disable iff (reset)
        mem_enable |-> mem_addr[1 : 0] == 2'b00)
        else begin
            $error("FAILED mem_addr 0x%08h, expected a word-aligned address", mem_addr);
            failures++;
        end

    // Any fetch at 0x400 or above means a check branch was taken
    no_trap_fetch: assert property (@(posedge clock) disable iff (reset)
        mem_enable |-> mem_addr < 32'h0000_0400)
        else begin
            $error("FAILED mem_addr 0x%08h, expected below 0x00000400", mem_addr);
            failures++;
        end

endmodule

bind ooo_core core_assertions i_assertions (
    .clock,
    .reset,
    .mem_enable,
    .mem_addr,
    .mem_ready
);

/* tb/tb_clock.sv */
module tb_clock (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock; // 100 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

/* tb/tb_top.sv */
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] trap_addr = 32'h0000_0400;
    localparam int timeout_cycles = 50000;

    logic        clock;
    logic        reset;
    logic        mem_enable;
    logic [31:0] mem_addr;
    logic [31:0] mem_rdata;
    logic        mem_ready;

    logic [31:0] program_memory [0 : 511];
    logic [31:0] next_pc; // Address of the next emitted word
    logic [31:0] done_addr;
    logic [31:0] rng_state;
    logic        pending;
    int          wait_count;

    tb_clock i_clock (.clock, .reset);

    ooo_core i_dut (
        .clock,
        .reset,
        .mem_enable,
        .mem_addr,
        .mem_rdata,
        .mem_ready
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] encode_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] funct3,
                                              input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] funct3, input logic [4:0] rd,
                                              input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd,
                                              input logic [6:0] opcode);
        return {imm, rd, opcode};
    endfunction

    function automatic logic [31:0] encode_b(input logic [31:0] offset, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] funct3);
        return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] encode_j(input logic [31:0] offset, input logic [4:0] rd);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit_word(input logic [31:0] instr);
        program_memory[next_pc[10:2]] = instr;
        next_pc = next_pc + 32'd4;
    endtask

    task automatic load_constant(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        logic [31:0] lower;
        upper = (value + 32'h800) >> 12; // Rounds for the signed low part
        lower = value - (upper << 12);
        emit_word(encode_u(upper[19:0], rd, 7'b0110111));
        emit_word(encode_i(lower[11:0], rd, 3'b000, rd, 7'b0010011));
    endtask

    task automatic jump_to_trap();
        emit_word(encode_j(trap_addr - next_pc, 5'd0));
    endtask

    // Branches to the trap range if rs differs from the expected value
    task automatic check_register(input logic [4:0] rs, input logic [31:0] expected);
        load_constant(5'd31, expected);
        emit_word(encode_b(trap_addr - next_pc, 5'd31, rs, 3'b001));
    endtask

    task automatic branch_over_trap(input logic [2:0] funct3, input logic [4:0] rs1,
                                    input logic [4:0] rs2);
        emit_word(encode_b(32'd8, rs2, rs1, funct3));
        jump_to_trap();
    endtask

    task automatic build_program();
        logic [31:0]        a;
        logic [31:0]        b;
        logic signed [31:0] a_signed;
        logic signed [31:0] b_signed;
        logic [31:0]        mark;
        a = 32'h8765_4321;
        b = 32'h1234_5675; // Shift amount 21
        a_signed = a;
        b_signed = b;
        next_pc = '0;
        load_constant(5'd1, a);
        load_constant(5'd2, b);

        emit_word(encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        check_register(5'd3, a + b);
        emit_word(encode_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        check_register(5'd4, a - b);
        emit_word(encode_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd5));
        check_register(5'd5, {31'b0, a_signed < b_signed});
        emit_word(encode_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd6));
        check_register(5'd6, {31'b0, a < b});
        emit_word(encode_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
        check_register(5'd7, a ^ b);
        emit_word(encode_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd8));
        check_register(5'd8, a | b);
        emit_word(encode_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd9));
        check_register(5'd9, a & b);
        emit_word(encode_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd10));
        check_register(5'd10, a << b[4:0]);
        emit_word(encode_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd11));
        check_register(5'd11, a >> b[4:0]);
        emit_word(encode_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd12));
        check_register(5'd12, a_signed >>> b[4:0]);

        emit_word(encode_i(-12'sd100, 5'd1, 3'b000, 5'd3, 7'b0010011));
        check_register(5'd3, a - 32'd100);
        emit_word(encode_i(12'd5, 5'd1, 3'b010, 5'd4, 7'b0010011));
        check_register(5'd4, {31'b0, a_signed < 32'sd5});
        emit_word(encode_i(12'd5, 5'd1, 3'b011, 5'd5, 7'b0010011));
        check_register(5'd5, {31'b0, a < 32'd5});
        emit_word(encode_i(12'hfff, 5'd1, 3'b100, 5'd6, 7'b0010011));
        check_register(5'd6, ~a); // Immediate sign-extends to all ones
        emit_word(encode_i(12'h0f0, 5'd1, 3'b110, 5'd7, 7'b0010011));
        check_register(5'd7, a | 32'h0000_00f0);
        emit_word(encode_i(12'h0ff, 5'd1, 3'b111, 5'd8, 7'b0010011));
        check_register(5'd8, a & 32'h0000_00ff);
        emit_word(encode_i(12'h007, 5'd1, 3'b001, 5'd9, 7'b0010011));
        check_register(5'd9, a << 7);
        emit_word(encode_i(12'h007, 5'd1, 3'b101, 5'd10, 7'b0010011));
        check_register(5'd10, a >> 7);
        emit_word(encode_i(12'h407, 5'd1, 3'b101, 5'd11, 7'b0010011));
        check_register(5'd11, a_signed >>> 7);

        // Chain longer than the station count
        emit_word(encode_i(12'd3, 5'd0, 3'b000, 5'd15, 7'b0010011));
        for (int i = 0; i < 8; i++) begin
            emit_word(encode_r(7'h00, 5'd15, 5'd15, 3'b000, 5'd15));
        end
        check_register(5'd15, 32'd3 << 8);

        mark = next_pc;
        emit_word(encode_u(20'h12345, 5'd17, 7'b0010111));
        check_register(5'd17, mark + 32'h1234_5000);

        mark = next_pc;
        emit_word(encode_j(32'd8, 5'd18));
        jump_to_trap();
        check_register(5'd18, mark + 32'd4);

        mark = next_pc;
        emit_word(encode_u(20'h00000, 5'd19, 7'b0010111));
        emit_word(encode_i(12'd17, 5'd19, 3'b000, 5'd20, 7'b1100111)); // Bit 0 cleared
        jump_to_trap();
        jump_to_trap();
        check_register(5'd20, mark + 32'd8);

        branch_over_trap(3'b000, 5'd1, 5'd1);
        branch_over_trap(3'b001, 5'd1, 5'd2);
        branch_over_trap(3'b100, 5'd1, 5'd2);
        branch_over_trap(3'b101, 5'd2, 5'd1);
        branch_over_trap(3'b110, 5'd2, 5'd1);
        branch_over_trap(3'b111, 5'd1, 5'd2);

        done_addr = next_pc;
        emit_word(encode_j(32'd0, 5'd0));
    endtask

    // Memory model with random latency
    always @(posedge clock) begin
        if (reset) begin
            mem_ready <= 1'b0;
            pending <= 1'b0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;
        end else if (mem_enable && !pending) begin
            pending <= 1'b1;
            rng_state <= xorshift32(rng_state);
            wait_count <= int'(xorshift32(rng_state) % 4);
        end else if (pending) begin
            if (wait_count == 0) begin
                mem_ready <= 1'b1;
                mem_rdata <= program_memory[mem_addr[10:2]];
                pending <= 1'b0;
            end else begin
                wait_count <= wait_count - 1;
            end
        end
    end

    initial begin
        int  cycles;
        logic done_seen;
        mem_ready = 1'b0;
        mem_rdata = '0;
        pending = 1'b0;
        wait_count = 0;
        rng_state = 32'd18;
        for (int i = 0; i < 512; i++) begin
            program_memory[i] = encode_i(12'(i * 4), 5'd0, 3'b000, 5'd0, 7'b0010011);
        end
        build_program();

        cycles = 0;
        done_seen = 1'b0;
        while (!done_seen && i_dut.i_assertions.failures == 0 && cycles < timeout_cycles) begin
            @(posedge clock);
            cycles++;
            if (!reset && mem_enable && mem_addr == done_addr) begin
                done_seen = 1'b1;
            end
        end
        repeat (2) @(posedge clock);

        if (done_seen && i_dut.i_assertions.failures == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            if (i_dut.i_assertions.failures != 0) begin
                $display("An assertion on the memory port or fetch address failed");
            end else begin
                $display("Timeout: the done address was never fetched");
            end
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

endmodule

/* verilog/alu_station.sv */
module alu_station import core_pkg::*; #(
    parameter tag_t tag = '0
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        issue_valid,
    input  issue_t      issue,
    output logic        busy,
    output logic        result_request,
    output word_t       result_value,
    input  result_bus_t result_bus
);
    alu_op_e  op_q;
    operand_t src1_q;
    operand_t src2_q;
    logic     own_result;
    word_t    a;
    word_t    b;

    assign own_result = busy && result_bus.valid && result_bus.tag == tag;
    assign result_request = busy && src1_q.ready && src2_q.ready;
    assign a = src1_q.value;
    assign b = src2_q.value;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (issue_valid) begin
            busy <= 1'b1;
        end else if (own_result) begin
            busy <= 1'b0; // Result is on the bus now
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            op_q <= issue.op;
            src1_q <= issue.src1;
            src2_q <= issue.src2;
        end else begin
            if (!src1_q.ready && result_bus.valid && result_bus.tag == src1_q.tag) begin
                src1_q.ready <= 1'b1;
                src1_q.value <= result_bus.value;
            end
            if (!src2_q.ready && result_bus.valid && result_bus.tag == src2_q.tag) begin
                src2_q.ready <= 1'b1;
                src2_q.value <= result_bus.value;
            end
        end
    end

    always_comb begin
        case (op_q)
            add: result_value = a + b;
            sub: result_value = a - b;
            or_op: result_value = a | b;
            and_op: result_value = a & b;
            xor_op: result_value = a ^ b;
            sll: result_value = a << b[4 : 0];
            srl: result_value = a >> b[4 : 0];
            sra: result_value = $signed(a) >>> b[4 : 0];
            sltu: result_value = {31'b0, a < b};
            slt: result_value = {31'b0, $signed(a) < $signed(b)};
            default: result_value = '0;
        endcase
    end

endmodule

/* verilog/core_pkg.sv */
package core_pkg;

    localparam int xlen = 32;
    localparam int default_station_count = 4;

    typedef logic [xlen - 1 : 0] word_t;
    typedef logic [4 : 0] reg_index_t;
    typedef logic [2 : 0] tag_t; // Up to 8 stations

    typedef enum logic [3 : 0] {
        add,
        sub,
        or_op,
        and_op,
        xor_op,
        sll,
        srl,
        sra,
        sltu,
        slt
    } alu_op_e;

    typedef enum logic [6 : 0] {
        op_imm = 7'b0010011,
        op     = 7'b0110011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        branch = 7'b1100011,
        jal    = 7'b1101111,
        jalr   = 7'b1100111
    } opcode_e;

    typedef struct packed {
        logic  ready; // Value valid, else wait for tag
        tag_t  tag;
        word_t value;
    } operand_t;

    typedef struct packed {
        alu_op_e  op;
        operand_t src1;
        operand_t src2;
    } issue_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t value;
    } result_bus_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetched_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

/* verilog/dispatch_unit.sv */
module dispatch_unit import core_pkg::*; #(
    parameter int station_count = default_station_count
) (
    input  fetched_t                   fetched,
    output logic                       fetch_taken,
    output redirect_t                  redirect,
    output reg_index_t                 src1_index,
    output reg_index_t                 src2_index,
    input  operand_t                   src1,
    input  operand_t                   src2,
    input  logic                       dest_busy,
    output logic                       alloc_valid,
    output reg_index_t                 alloc_index,
    output tag_t                       alloc_tag,
    output logic                       reg_write_valid,
    output reg_index_t                 reg_write_index,
    output word_t                      reg_write_value,
    input  logic [station_count - 1 : 0] station_busy,
    output logic [station_count - 1 : 0] issue_valid,
    output issue_t                     issue
);
    opcode_e                    opcode;
    logic [2 : 0]               funct3;
    reg_index_t                 rd;
    word_t                      imm_i;
    word_t                      imm_b;
    word_t                      imm_u;
    word_t                      imm_j;
    word_t                      link_value;
    alu_op_e                    alu_op;
    logic                       branch_taken;
    logic                       free_found;
    tag_t                       free_tag;
    logic [station_count - 1 : 0] free_select;

    assign opcode = opcode_e'(fetched.instr[6 : 0]);
    assign funct3 = fetched.instr[14 : 12];
    assign rd = fetched.instr[11 : 7];
    assign src1_index = fetched.instr[19 : 15];
    assign src2_index = fetched.instr[24 : 20];

    assign imm_i = {{21{fetched.instr[31]}}, fetched.instr[30 : 20]};
    assign imm_b = {{20{fetched.instr[31]}}, fetched.instr[7], fetched.instr[30 : 25],
                    fetched.instr[11 : 8], 1'b0};
    assign imm_u = {fetched.instr[31 : 12], 12'b0};
    assign imm_j = {{12{fetched.instr[31]}}, fetched.instr[19 : 12], fetched.instr[20],
                    fetched.instr[30 : 21], 1'b0};
    assign link_value = fetched.pc + 32'd4;

    assign alloc_index = rd; // Also the lookup for dest_busy
    assign alloc_tag = free_tag;
    assign reg_write_index = rd;

    always_comb begin
        case (funct3)
            3'b000: alu_op = (opcode == op && fetched.instr[30]) ? sub : add;
            3'b001: alu_op = sll;
            3'b010: alu_op = slt;
            3'b011: alu_op = sltu;
            3'b100: alu_op = xor_op;
            3'b101: alu_op = fetched.instr[30] ? sra : srl;
            3'b110: alu_op = or_op;
            default: alu_op = and_op;
        endcase
    end

    assign issue.op = alu_op;
    assign issue.src1 = src1;
    assign issue.src2 = (opcode == op) ? src2 : '{ready: 1'b1, tag: '0, value: imm_i};

    always_comb begin
        case (funct3)
            3'b000: branch_taken = src1.value == src2.value;
            3'b001: branch_taken = src1.value != src2.value;
            3'b100: branch_taken = $signed(src1.value) < $signed(src2.value);
            3'b101: branch_taken = $signed(src1.value) >= $signed(src2.value);
            3'b110: branch_taken = src1.value < src2.value;
            3'b111: branch_taken = src1.value >= src2.value;
            default: branch_taken = 1'b0;
        endcase
    end

    // Lowest free station wins
    always_comb begin
        free_found = 1'b0;
        free_tag = '0;
        free_select = '0;
        for (int i = station_count - 1; i >= 0; i--) begin
            if (!station_busy[i]) begin
                free_found = 1'b1;
                free_tag = tag_t'(i);
                free_select = '0;
                free_select[i] = 1'b1;
            end
        end
    end

    always_comb begin
        fetch_taken = 1'b0;
        redirect.valid = 1'b0;
        redirect.target = fetched.pc + imm_b;
        alloc_valid = 1'b0;
        issue_valid = '0;
        reg_write_valid = 1'b0;
        reg_write_value = link_value;
        if (fetched.valid) begin
            case (opcode)
                op_imm, op: begin
                    if (free_found) begin
                        fetch_taken = 1'b1;
                        alloc_valid = 1'b1;
                        issue_valid = free_select;
                    end
                end
                lui, auipc: begin
                    fetch_taken = 1'b1;
                    reg_write_valid = 1'b1;
                    reg_write_value = (opcode == lui) ? imm_u : fetched.pc + imm_u;
                end
                branch: begin
                    if (src1.ready && src2.ready) begin
                        fetch_taken = 1'b1;
                        redirect.valid = branch_taken;
                    end
                end
                jal: begin
                    if (!dest_busy) begin
                        fetch_taken = 1'b1;
                        redirect.valid = 1'b1;
                        redirect.target = fetched.pc + imm_j;
                        reg_write_valid = 1'b1;
                    end
                end
                jalr: begin
                    if (!dest_busy && src1.ready) begin
                        fetch_taken = 1'b1;
                        redirect.valid = 1'b1;
                        redirect.target = (src1.value + imm_i) & ~32'd1;
                        reg_write_valid = 1'b1;
                    end
                end
                default: fetch_taken = 1'b1; // Unknown opcode is a no-op
            endcase
        end
    end

endmodule

/* verilog/instruction_fetch.sv */
module instruction_fetch import core_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    output logic      mem_enable,
    output word_t     mem_addr,
    input  word_t     mem_rdata,
    input  logic      mem_ready,
    output fetched_t  fetched,
    input  logic      fetch_taken,
    input  redirect_t redirect
);
    word_t pc; // Address of the next request
    logic  cancel;
    logic  fetched_valid;
    word_t fetched_pc;
    word_t fetched_instr;
    logic  start_request;
    word_t start_addr;

    assign start_addr = redirect.valid ? redirect.target : pc;
    assign start_request = !mem_enable && (!fetched_valid || fetch_taken || redirect.valid);
    assign fetched = '{valid: fetched_valid, pc: fetched_pc, instr: fetched_instr};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= '0;
            mem_enable <= 1'b0;
            mem_addr <= '0;
            cancel <= 1'b0;
            fetched_valid <= 1'b0;
        end else begin
            if (mem_enable && mem_ready) begin
                mem_enable <= 1'b0;
                cancel <= 1'b0;
            end

            if (redirect.valid) begin
                pc <= redirect.target;
                fetched_valid <= 1'b0;
                if (mem_enable && !mem_ready) begin
                    cancel <= 1'b1; // Late data gets dropped
                end
            end else if (mem_enable && mem_ready && !cancel) begin
                fetched_valid <= 1'b1;
                pc <= mem_addr + 32'd4;
            end else if (fetch_taken) begin
                fetched_valid <= 1'b0;
            end

            if (start_request) begin
                mem_enable <= 1'b1;
                mem_addr <= start_addr;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (mem_enable && mem_ready && !cancel && !redirect.valid) begin
            fetched_pc <= mem_addr;
            fetched_instr <= mem_rdata;
        end
    end

endmodule

/* verilog/ooo_core.sv */
module ooo_core import core_pkg::*; #(
    parameter int station_count = default_station_count
) (
    input  logic  clock,
    input  logic  reset,
    output logic  mem_enable,
    output word_t mem_addr,
    input  word_t mem_rdata,
    input  logic  mem_ready
);
    fetched_t                   fetched;
    logic                       fetch_taken;
    redirect_t                  redirect;
    reg_index_t                 src1_index;
    reg_index_t                 src2_index;
    operand_t                   src1;
    operand_t                   src2;
    logic                       dest_busy;
    logic                       alloc_valid;
    reg_index_t                 alloc_index;
    tag_t                       alloc_tag;
    logic                       reg_write_valid;
    reg_index_t                 reg_write_index;
    word_t                      reg_write_value;
    logic [station_count - 1 : 0] station_busy;
    logic [station_count - 1 : 0] issue_valid;
    logic [station_count - 1 : 0] result_request;
    issue_t                     issue;
    word_t                      result_values [station_count];
    result_bus_t                result_bus;

    instruction_fetch i_fetch (
        .clock, .reset,
        .mem_enable, .mem_addr, .mem_rdata, .mem_ready,
        .fetched, .fetch_taken, .redirect
    );

    dispatch_unit #(.station_count(station_count)) i_dispatch (
        .fetched, .fetch_taken, .redirect,
        .src1_index, .src2_index, .src1, .src2, .dest_busy,
        .alloc_valid, .alloc_index, .alloc_tag,
        .reg_write_valid, .reg_write_index, .reg_write_value,
        .station_busy, .issue_valid, .issue
    );

    register_status i_registers (
        .clock, .reset,
        .src1_index, .src2_index, .src1, .src2, .dest_busy,
        .alloc_valid, .alloc_index, .alloc_tag,
        .reg_write_valid, .reg_write_index, .reg_write_value,
        .result_bus
    );

    for (genvar i = 0; i < station_count; i++) begin : g_station
        alu_station #(.tag(tag_t'(i))) i_station (
            .clock, .reset,
            .issue_valid(issue_valid[i]),
            .issue,
            .busy(station_busy[i]),
            .result_request(result_request[i]),
            .result_value(result_values[i]),
            .result_bus
        );
    end

    result_bus_arbiter #(.station_count(station_count)) i_arbiter (
        .clock, .reset,
        .result_request, .result_values, .result_bus
    );

endmodule

/* verilog/register_status.sv */
module register_status import core_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  reg_index_t  src1_index,
    input  reg_index_t  src2_index,
    output operand_t    src1,
    output operand_t    src2,
    output logic        dest_busy,
    input  logic        alloc_valid,
    input  reg_index_t  alloc_index,
    input  tag_t        alloc_tag,
    input  logic        reg_write_valid,
    input  reg_index_t  reg_write_index,
    input  word_t       reg_write_value,
    input  result_bus_t result_bus
);
    word_t         values [1 : 31];
    tag_t          tags [1 : 31];
    logic [31 : 1] busy;

    function automatic operand_t lookup(reg_index_t index);
        operand_t result;
        result = '{ready: 1'b1, tag: '0, value: '0};
        if (index != '0) begin
            if (!busy[index]) begin
                result.value = values[index];
            end else if (result_bus.valid && result_bus.tag == tags[index]) begin
                result.value = result_bus.value; // Forward from the bus
            end else begin
                result.ready = 1'b0;
                result.tag = tags[index];
            end
        end
        return result;
    endfunction

    assign src1 = lookup(src1_index);
    assign src2 = lookup(src2_index);
    assign dest_busy = (alloc_index != '0) && busy[alloc_index];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= '0;
        end else begin
            for (int i = 1; i < 32; i++) begin
                if (busy[i] && result_bus.valid && result_bus.tag == tags[i]) begin
                    busy[i] <= 1'b0;
                end
            end
            if (alloc_valid && alloc_index != '0) begin
                busy[alloc_index] <= 1'b1; // Newer producer wins
            end
            if (reg_write_valid && reg_write_index != '0) begin
                busy[reg_write_index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 1; i < 32; i++) begin
            if (busy[i] && result_bus.valid && result_bus.tag == tags[i]) begin
                values[i] <= result_bus.value;
            end
        end
        if (alloc_valid && alloc_index != '0) begin
            tags[alloc_index] <= alloc_tag;
        end
        if (reg_write_valid && reg_write_index != '0) begin
            values[reg_write_index] <= reg_write_value;
        end
    end

endmodule

/* verilog/result_bus_arbiter.sv */
module result_bus_arbiter import core_pkg::*; #(
    parameter int station_count = default_station_count
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [station_count - 1 : 0] result_request,
    input  word_t                      result_values [station_count],
    output result_bus_t                result_bus
);
    logic  grant_found;
    tag_t  grant_tag;
    word_t grant_value;
    logic  bus_valid;
    tag_t  bus_tag;
    word_t bus_value;

    assign result_bus = '{valid: bus_valid, tag: bus_tag, value: bus_value};

    always_comb begin
        grant_found = 1'b0;
        grant_tag = '0;
        grant_value = '0;
        for (int i = station_count - 1; i >= 0; i--) begin
            // Skip the station already on the bus
            if (result_request[i] && !(bus_valid && bus_tag == tag_t'(i))) begin
                grant_found = 1'b1;
                grant_tag = tag_t'(i);
                grant_value = result_values[i];
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            bus_valid <= 1'b0;
        end else begin
            bus_valid <= grant_found;
        end
    end

    always_ff @(posedge clock) begin
        bus_tag <= grant_tag;
        bus_value <= grant_value;
    end

endmodule
